/* compile.f */
rtl/mips_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pipe_stage_reg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/instr_decode.sv
rtl/instr_execute.sv
rtl/wb_result.sv
rtl/datapath.sv
testbench/tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
# build the core testbench with Verilator, run it, and decide from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath \
   -f compile.f -o sim_tb_datapath
./obj_dir/sim_tb_datapath | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* testbench/tb_datapath.sv */
// testbench for the integer core
// sends a random instruction stream under input credits, withholds
// output credits for random stretches and checks every retirement
// record against a program-order reference model
`default_nettype none
`timescale 1ns/10ps

module tb_datapath;

   localparam int INSTR_DEPTH = 4;
   localparam int RES_CREDITS = 2;
   localparam int N_INSTR     = 400;
   localparam int TIMEOUT     = 40 * N_INSTR + 200;

   // supported R-type functs and I-type opcodes in MIPS encoding
   localparam logic [5:0] R_FUNCT [10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                                           6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02};
   localparam logic [5:0] I_OPCODE [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

   logic               CLK;
   logic               rst_n;
   logic               instr_valid;
   logic [31:0]        instr;
   logic               instr_credit;
   logic               res_valid;
   pipe_pkg::retire_t  res;
   logic               res_credit;

   logic [31:0]        lfsr;
   logic [31:0]        prog [N_INSTR];
   pipe_pkg::retire_t  exp_rec [N_INSTR];
   pipe_pkg::retire_t  exp_now;
   int                 in_cred = INSTR_DEPTH;   // credits held by the source
   int                 out_cred = RES_CREDITS;  // credits held by the core
   int                 owed = 0;                // records not yet credited back
   int                 chk_idx = 0;
   int                 cycles;
   int                 value_errs = 0;
   int                 other_errs = 0;

   datapath #(.INSTR_DEPTH(INSTR_DEPTH), .RES_CREDITS(RES_CREDITS)) u_datapath (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .res_valid    (res_valid),
      .res          (res),
      .res_credit   (res_credit)
   );

   initial CLK = 1'b0;
   always #2 CLK = ~CLK;

   ////////////////////////////////////////////////////////////////////
   // random source and reference model
   ////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] r_result(input logic [5:0] fn, input logic [31:0] a,
                                            input logic [31:0] b, input logic [4:0] sh);
      case (fn)
         6'h21:   return a + b;
         6'h23:   return a - b;
         6'h24:   return a & b;
         6'h25:   return a | b;
         6'h26:   return a ^ b;
         6'h27:   return ~(a | b);
         6'h2a:   return {31'b0, $signed(a) < $signed(b)};
         6'h2b:   return {31'b0, a < b};
         6'h00:   return b << sh;
         default: return b >> sh;   // srl
      endcase
   endfunction

   function automatic logic [31:0] i_result(input logic [5:0] op, input logic [31:0] a,
                                            input logic [15:0] imm);
      logic [31:0] sx;
      logic [31:0] zx;
      sx = {{16{imm[15]}}, imm};
      zx = {16'h0000, imm};
      case (op)
         6'h09:   return a + sx;
         6'h0a:   return {31'b0, $signed(a) < $signed(sx)};
         6'h0c:   return a & zx;
         6'h0d:   return a | zx;
         6'h0e:   return a ^ zx;
         default: return {imm, 16'h0000};   // lui
      endcase
   endfunction

   task automatic build_program();
      logic [31:0] ref_regs [32];
      logic [4:0]  sel;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  sh;
      logic [4:0]  dst;
      logic [15:0] imm;
      logic [5:0]  op;
      logic [5:0]  fn;
      logic [31:0] val;
      logic        legal;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end
      for (int n = 0; n < N_INSTR; n++) begin
         sel   = 5'(take_bits(5));
         rs    = 5'(take_bits(3));   // small pool keeps dependencies close
         rt    = 5'(take_bits(3));
         rd    = 5'(take_bits(3));
         sh    = 5'(take_bits(5));
         imm   = 16'(take_bits(16));
         legal = 1'b1;
         op    = 6'h00;
         fn    = 6'h00;
         dst   = rt;
         val   = '0;
         if (sel < 5'd12) begin
            fn  = R_FUNCT[sel % 5'd10];
            dst = rd;
            val = r_result(fn, ref_regs[rs], ref_regs[rt], sh);
         end else if (sel < 5'd28) begin
            op  = I_OPCODE[(sel - 5'd12) % 5'd6];
            val = i_result(op, ref_regs[rs], imm);
         end else begin
            legal = 1'b0;
            op    = sel[0] ? 6'h23 : 6'h00;   // lw opcode or jr funct
            fn    = 6'h08;
            dst   = sel[0] ? rt : rd;
         end
         if (op == 6'h00) begin
            prog[n] = {op, rs, rt, rd, sh, fn};
         end else begin
            prog[n] = {op, rs, rt, imm};
         end
         exp_rec[n].wsel    = dst;
         exp_rec[n].wdat    = val;
         exp_rec[n].regwr   = legal && (dst != 5'd0);
         exp_rec[n].illegal = !legal;
         if (exp_rec[n].regwr) begin
            ref_regs[dst] = val;
         end
      end
   endtask

   task automatic report_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
      value_errs++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
   endtask

   task automatic note_error(input string msg);
      other_errs++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   ////////////////////////////////////////////////////////////////////
   // credit bookkeeping and checks
   ////////////////////////////////////////////////////////////////////
   always @(posedge CLK) begin
      if (!rst_n) begin
         in_cred  <= INSTR_DEPTH;
         out_cred <= RES_CREDITS;
         owed     <= 0;
         chk_idx  <= 0;
      end else begin
         in_cred  <= in_cred - int'(instr_valid) + int'(instr_credit);
         out_cred <= out_cred - int'(res_valid) + int'(res_credit);
         owed     <= owed + int'(res_valid) - int'(res_credit);
         chk_idx  <= chk_idx + int'(res_valid);
      end
   end

   assign exp_now = (chk_idx < N_INSTR) ? exp_rec[chk_idx] : '0;

   a_rec_count : assert property (@(posedge CLK) disable iff (!rst_n)
      res_valid |-> (chk_idx < N_INSTR))
      else note_error("record retired after the last instruction");
   a_illegal : assert property (@(posedge CLK) disable iff (!rst_n)
      res_valid |-> (res.illegal == exp_now.illegal))
      else report_value("res.illegal", $sampled(exp_now.illegal), $sampled(res.illegal));
   a_regwr : assert property (@(posedge CLK) disable iff (!rst_n)
      res_valid |-> (res.regwr == exp_now.regwr))
      else report_value("res.regwr", $sampled(exp_now.regwr), $sampled(res.regwr));
   a_wsel : assert property (@(posedge CLK) disable iff (!rst_n)
      (res_valid && !exp_now.illegal) |-> (res.wsel == exp_now.wsel))
      else report_value("res.wsel", $sampled(exp_now.wsel), $sampled(res.wsel));
   a_wdat : assert property (@(posedge CLK) disable iff (!rst_n)
      (res_valid && !exp_now.illegal) |-> (res.wdat == exp_now.wdat))
      else report_value("res.wdat", $sampled(exp_now.wdat), $sampled(res.wdat));
   a_out_credit : assert property (@(posedge CLK) disable iff (!rst_n)
      res_valid |-> (out_cred > 0))
      else note_error("result sent while the core held no output credit");
   a_in_credit : assert property (@(posedge CLK) disable iff (!rst_n)
      instr_credit |-> (in_cred < INSTR_DEPTH))
      else note_error("more input credits returned than instructions sent");

   ////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////
   initial begin
      int          sent;
      int          stall_left;
      logic [31:0] gap;
      logic        coin;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      res_credit  = 1'b0;
      lfsr        = 32'd32;
      sent        = 0;
      stall_left  = 0;
      build_program();
      repeat (8) @(negedge CLK);
      rst_n = 1'b1;
      while (chk_idx < N_INSTR) begin
         @(negedge CLK);
         gap = take_bits(2);   // source idles one beat in four
         if ((sent < N_INSTR) && (in_cred > 0) && (gap != 0)) begin
            instr_valid = 1'b1;
            instr       = prog[sent];
            sent++;
         end else begin
            instr_valid = 1'b0;
         end
         if (stall_left > 0) begin
            stall_left--;
         end else if (take_bits(3) == 0) begin
            stall_left = int'(take_bits(5));   // sink withholds credits
         end
         coin       = take_bits(1) == 1;
         res_credit = (stall_left == 0) && (owed > 0) && coin;
      end
      // drain and hand back every outstanding output credit
      instr_valid = 1'b0;
      repeat (RES_CREDITS + 8) begin
         @(negedge CLK);
         res_credit = (owed > 0);
      end
      res_credit = 1'b0;
      @(negedge CLK);
      a_in_drained : assert (in_cred == INSTR_DEPTH)
         else note_error("input credits missing after the pipeline drained");
      a_out_drained : assert (out_cred == RES_CREDITS)
         else note_error("output credits out of balance after the pipeline drained");
      $display("summary: %0d of %0d records checked, %0d value errors, %0d other errors",
               chk_idx, N_INSTR, value_errs, other_errs);
      if ((value_errs == 0) && (other_errs == 0)) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge CLK);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d of %0d records retired",
               cycles, chk_idx, N_INSTR);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
// integer core top level
// decode, execute and result stages around the register file, with
// credit flow control on the instruction input and the result output
`default_nettype none
`timescale 1ns/10ps

module datapath #(
   parameter int INSTR_DEPTH = 4,   // also the input credits
   parameter int RES_CREDITS = 2
) (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                instr_valid,
   input  mips_isa_pkg::word_t instr,
   output logic                instr_credit,
   output logic                res_valid,
   output pipe_pkg::retire_t   res,
   input  logic                res_credit
);

   mips_isa_pkg::reg_idx_t rsel1;
   mips_isa_pkg::reg_idx_t rsel2;
   mips_isa_pkg::reg_idx_t wsel;
   mips_isa_pkg::word_t    rdat1;
   mips_isa_pkg::word_t    rdat2;
   mips_isa_pkg::word_t    wdat;
   logic                   wen;
   logic                   dec_valid;
   logic                   ex_ready;
   logic                   ex_valid;
   logic                   wb_ready;
   logic                   fwd_valid;
   pipe_pkg::dec_ex_t      dec;
   pipe_pkg::ex_wb_t       ex;
   pipe_pkg::ex_wb_t       fwd;

   //////////////////////////////////////////////////////////////////////
   // stages
   //////////////////////////////////////////////////////////////////////
   instr_decode #(.INSTR_DEPTH(INSTR_DEPTH)) u_instr_decode (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .ex_ready     (ex_ready),
      .rsel1        (rsel1),
      .rsel2        (rsel2),
      .rdat1        (rdat1),
      .rdat2        (rdat2),
      .dec_valid    (dec_valid),
      .dec          (dec)
   );

   register_file u_register_file (
      .CLK   (CLK),
      .rst_n (rst_n),
      .rsel1 (rsel1),
      .rsel2 (rsel2),
      .rdat1 (rdat1),
      .rdat2 (rdat2),
      .wen   (wen),
      .wsel  (wsel),
      .wdat  (wdat)
   );

   instr_execute u_instr_execute (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .dec_valid (dec_valid),
      .dec       (dec),
      .wb_ready  (wb_ready),
      .ex_ready  (ex_ready),
      .fwd_valid (fwd_valid),
      .fwd       (fwd),
      .ex_valid  (ex_valid),
      .ex        (ex)
   );

   // writeback and retirement
   wb_result #(.RES_CREDITS(RES_CREDITS)) u_wb_result (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .ex_valid   (ex_valid),
      .ex         (ex),
      .wb_ready   (wb_ready),
      .fwd_valid  (fwd_valid),
      .fwd        (fwd),
      .wen        (wen),
      .wsel       (wsel),
      .wdat       (wdat),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

endmodule

`default_nettype wire

/* rtl/wb_result.sv */
// result stage
// holds the executed instruction until an output credit is available,
// then retires it, writing the register file and sending the record
`default_nettype none
`timescale 1ns/10ps

module wb_result #(
   parameter int RES_CREDITS = 2
) (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   ex_valid,
   input  pipe_pkg::ex_wb_t       ex,
   output logic                   wb_ready,
   output logic                   fwd_valid,
   output pipe_pkg::ex_wb_t       fwd,
   output logic                   wen,
   output mips_isa_pkg::reg_idx_t wsel,
   output mips_isa_pkg::word_t    wdat,
   output logic                   res_valid,
   output pipe_pkg::retire_t      res,
   input  logic                   res_credit
);

   localparam int CW = $clog2(RES_CREDITS + 1);

   pipe_pkg::ex_wb_t wb;
   logic             wb_valid;
   logic             retire;
   logic [CW-1:0]    credits;

   pipe_stage_reg #(.payload_t(pipe_pkg::ex_wb_t)) u_ex_wb (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .in_valid  (ex_valid),
      .in_data   (ex),
      .advance   (wb_ready),
      .out_valid (wb_valid),
      .out_data  (wb)
   );

   assign retire   = wb_valid && (credits != '0);
   assign wb_ready = !wb_valid || retire;

   // output credit counter
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         credits <= CW'(RES_CREDITS);
      end else begin
         credits <= credits - CW'(retire) + CW'(res_credit);
      end
   end

   assign fwd_valid = wb_valid;   // held entry whether retiring or not
   assign fwd       = wb;
   assign wen       = retire && wb.regwr;
   assign wsel      = wb.wsel;
   assign wdat      = wb.wdat;
   assign res_valid = retire;

   always_comb begin
      res.wsel    = wb.wsel;
      res.wdat    = wb.wdat;
      res.regwr   = wb.regwr;
      res.illegal = wb.illegal;
   end

   // sink returned more credits than it was given
   a_credit_max : assert property (@(posedge CLK) disable iff (!rst_n)
      credits <= CW'(RES_CREDITS));

endmodule

`default_nettype wire

/* rtl/instr_execute.sv */
// execute stage
// registers the decoded instruction, forwards operands from the entry
// held in the result stage, selects the second operand and runs the ALU
`default_nettype none
`timescale 1ns/10ps

module instr_execute (
   input  logic              CLK,
   input  logic              rst_n,
   input  logic              dec_valid,
   input  pipe_pkg::dec_ex_t dec,
   input  logic              wb_ready,
   output logic              ex_ready,
   input  logic              fwd_valid,
   input  pipe_pkg::ex_wb_t  fwd,
   output logic              ex_valid,
   output pipe_pkg::ex_wb_t  ex
);

   pipe_pkg::dec_ex_t   de;
   logic                de_valid;
   logic                fwd_rs;
   logic                fwd_rt;
   mips_isa_pkg::word_t op_a;
   mips_isa_pkg::word_t rt_val;
   mips_isa_pkg::word_t op_b;
   mips_isa_pkg::word_t alu_res;

   assign ex_ready = !de_valid || wb_ready;

   pipe_stage_reg #(.payload_t(pipe_pkg::dec_ex_t)) u_dec_ex (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .in_valid  (dec_valid),
      .in_data   (dec),
      .advance   (ex_ready),
      .out_valid (de_valid),
      .out_data  (de)
   );

   //////////////////////////////////////////////////////////////////////
   // forwarding and operand select
   //////////////////////////////////////////////////////////////////////
   // older writes already went through the register file bypass
   assign fwd_rs = fwd_valid && fwd.regwr && (fwd.wsel == de.rs);
   assign fwd_rt = fwd_valid && fwd.regwr && (fwd.wsel == de.rt);
   assign op_a   = fwd_rs ? fwd.wdat : de.rdat1;
   assign rt_val = fwd_rt ? fwd.wdat : de.rdat2;
   assign op_b   = de.alu_src ? de.imm : rt_val;

   alu u_alu (
      .op    (de.alu_op),
      .op1   (op_a),
      .op2   (op_b),
      .shamt (de.shamt),
      .res   (alu_res)
   );

   assign ex_valid = de_valid;

   always_comb begin
      ex.wsel    = de.wsel;
      ex.wdat    = alu_res;
      ex.regwr   = de.regwr;
      ex.illegal = de.illegal;
   end

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
// instruction decode stage
// buffers incoming instructions in a FIFO, returns one input credit
// per pop, splits the head instruction into fields, extends the
// immediate and reads the register file
`default_nettype none
`timescale 1ns/10ps

module instr_decode #(
   parameter int INSTR_DEPTH = 4
) (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  mips_isa_pkg::word_t    instr,
   output logic                   instr_credit,
   input  logic                   ex_ready,
   output mips_isa_pkg::reg_idx_t rsel1,
   output mips_isa_pkg::reg_idx_t rsel2,
   input  mips_isa_pkg::word_t    rdat1,
   input  mips_isa_pkg::word_t    rdat2,
   output logic                   dec_valid,
   output pipe_pkg::dec_ex_t      dec
);

   localparam int AW = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
   localparam int CW = $clog2(INSTR_DEPTH + 1);

   mips_isa_pkg::word_t   fifo_mem [INSTR_DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [CW-1:0]         count;
   logic                  full;
   logic                  pop;
   logic                  legal;
   mips_isa_pkg::word_t   head;
   mips_isa_pkg::opcode_t opcode;
   mips_isa_pkg::funct_t  funct;
   logic [15:0]           imm16;

   //////////////////////////////////////////////////////////////////////
   // instruction FIFO
   //////////////////////////////////////////////////////////////////////
   assign full      = (count == CW'(INSTR_DEPTH));
   assign dec_valid = (count != '0);
   assign pop       = dec_valid && ex_ready;
   assign head      = fifo_mem[rd_ptr];

   always_ff @(posedge CLK) begin
      if (instr_valid) begin
         fifo_mem[wr_ptr] <= instr;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         instr_credit <= 1'b0;
      end else begin
         if (instr_valid) begin
            wr_ptr <= (wr_ptr == AW'(INSTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == AW'(INSTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count        <= count + CW'(instr_valid) - CW'(pop);
         instr_credit <= pop;   // one credit back per entry leaving
      end
   end

   // source spent a credit it did not hold
   a_no_overrun : assert property (@(posedge CLK) disable iff (!rst_n)
      instr_valid |-> !full);

   //////////////////////////////////////////////////////////////////////
   // field decode
   //////////////////////////////////////////////////////////////////////
   assign opcode = mips_isa_pkg::opcode_t'(head[31:26]);
   assign funct  = mips_isa_pkg::funct_t'(head[5:0]);
   assign imm16  = head[15:0];
   assign rsel1  = head[25:21];
   assign rsel2  = head[20:16];

   always_comb begin
      dec         = '0;
      dec.rs      = rsel1;
      dec.rt      = rsel2;
      dec.rdat1   = rdat1;
      dec.rdat2   = rdat2;
      dec.shamt   = head[10:6];
      dec.wsel    = rsel2;             // I-type writes rt
      dec.alu_src = 1'b1;
      dec.imm     = {16'b0, imm16};    // zero extend unless overridden
      dec.alu_op  = mips_isa_pkg::ALU_ADD;
      legal       = 1'b1;
      case (opcode)
         mips_isa_pkg::OP_RTYPE: begin
            dec.wsel    = head[15:11];
            dec.alu_src = 1'b0;
            case (funct)
               mips_isa_pkg::F_ADDU: dec.alu_op = mips_isa_pkg::ALU_ADD;
               mips_isa_pkg::F_SUBU: dec.alu_op = mips_isa_pkg::ALU_SUB;
               mips_isa_pkg::F_AND:  dec.alu_op = mips_isa_pkg::ALU_AND;
               mips_isa_pkg::F_OR:   dec.alu_op = mips_isa_pkg::ALU_OR;
               mips_isa_pkg::F_XOR:  dec.alu_op = mips_isa_pkg::ALU_XOR;
               mips_isa_pkg::F_NOR:  dec.alu_op = mips_isa_pkg::ALU_NOR;
               mips_isa_pkg::F_SLT:  dec.alu_op = mips_isa_pkg::ALU_SLT;
               mips_isa_pkg::F_SLTU: dec.alu_op = mips_isa_pkg::ALU_SLTU;
               mips_isa_pkg::F_SLL:  dec.alu_op = mips_isa_pkg::ALU_SLL;
               mips_isa_pkg::F_SRL:  dec.alu_op = mips_isa_pkg::ALU_SRL;
               default:              legal      = 1'b0;
            endcase
         end
         mips_isa_pkg::OP_ADDIU: dec.imm    = {{16{imm16[15]}}, imm16};
         mips_isa_pkg::OP_SLTI: begin
            dec.alu_op = mips_isa_pkg::ALU_SLT;
            dec.imm    = {{16{imm16[15]}}, imm16};
         end
         mips_isa_pkg::OP_ANDI:  dec.alu_op = mips_isa_pkg::ALU_AND;
         mips_isa_pkg::OP_ORI:   dec.alu_op = mips_isa_pkg::ALU_OR;
         mips_isa_pkg::OP_XORI:  dec.alu_op = mips_isa_pkg::ALU_XOR;
         mips_isa_pkg::OP_LUI:   dec.alu_op = mips_isa_pkg::ALU_LUI;
         default:                legal      = 1'b0;
      endcase
      dec.illegal = !legal;
      dec.regwr   = legal && (dec.wsel != '0);   // $0 never written
   end

endmodule

`default_nettype wire

/* rtl/alu.sv */
// integer ALU
// combinational, modulo 2^32 arithmetic, signed and unsigned set on
// less than, logical shifts of op2 by shamt and load upper immediate
`default_nettype none
`timescale 1ns/10ps

module alu (
   input  mips_isa_pkg::alu_op_t op,
   input  mips_isa_pkg::word_t   op1,
   input  mips_isa_pkg::word_t   op2,
   input  logic [4:0]            shamt,
   output mips_isa_pkg::word_t   res
);

   always_comb begin
      case (op)
         mips_isa_pkg::ALU_ADD:  res = op1 + op2;   // wraps without an overflow trap
         mips_isa_pkg::ALU_SUB:  res = op1 - op2;
         mips_isa_pkg::ALU_AND:  res = op1 & op2;
         mips_isa_pkg::ALU_OR:   res = op1 | op2;
         mips_isa_pkg::ALU_XOR:  res = op1 ^ op2;
         mips_isa_pkg::ALU_NOR:  res = ~(op1 | op2);
         mips_isa_pkg::ALU_SLT: begin
            res = {31'b0, $signed(op1) < $signed(op2)};
         end
         mips_isa_pkg::ALU_SLTU: begin
            res = {31'b0, op1 < op2};
         end
         // shifts act on the rt operand
         mips_isa_pkg::ALU_SLL:  res = op2 << shamt;
         mips_isa_pkg::ALU_SRL:  res = op2 >> shamt;
         mips_isa_pkg::ALU_LUI:  res = {op2[15:0], 16'b0};
         default:                res = '0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
// register file
// 32 words with two combinational read ports and one write port,
// register 0 reads as zero, a read of the register being written
// sees the new value in the same cycle
`default_nettype none
`timescale 1ns/10ps

module register_file (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  mips_isa_pkg::reg_idx_t rsel1,
   input  mips_isa_pkg::reg_idx_t rsel2,
   output mips_isa_pkg::word_t    rdat1,
   output mips_isa_pkg::word_t    rdat2,
   input  logic                   wen,
   input  mips_isa_pkg::reg_idx_t wsel,
   input  mips_isa_pkg::word_t    wdat
);

   mips_isa_pkg::word_t regs [32];

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   // read ports with write bypass
   assign rdat1 = (rsel1 == '0)                  ? '0   :
                  (wen && (wsel == rsel1))       ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == '0)                  ? '0   :
                  (wen && (wsel == rsel2))       ? wdat : regs[rsel2];

endmodule

`default_nettype wire

/* rtl/pipe_stage_reg.sv */
// pipeline stage register
// holds one payload of any type with its valid bit, loads on advance
// and keeps its contents while the next stage stalls
`default_nettype none
`timescale 1ns/10ps

module pipe_stage_reg #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     CLK,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   input  logic     advance,
   output logic     out_valid,
   output payload_t out_data
);

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (advance) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (advance) begin
         out_data <= in_data;   // payload follows the valid bit
      end
   end

endmodule

`default_nettype wire

/* rtl/pipe_pkg.sv */
// pipeline payload definitions
// stage-to-stage payloads of the core and the retirement record
// that leaves at the top-level result port
`default_nettype none

package pipe_pkg;

   //////////////////////////////////////////////////////////////////////
   // decode to execute
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      mips_isa_pkg::alu_op_t  alu_op;
      mips_isa_pkg::reg_idx_t rs;        // forwarding compare
      mips_isa_pkg::reg_idx_t rt;
      mips_isa_pkg::reg_idx_t wsel;      // destination rd or rt
      mips_isa_pkg::word_t    rdat1;
      mips_isa_pkg::word_t    rdat2;
      mips_isa_pkg::word_t    imm;       // already extended
      logic [4:0]             shamt;
      logic                   alu_src;   // 1 selects imm
      logic                   regwr;
      logic                   illegal;
   } dec_ex_t;

   // execute to result
   typedef struct packed {
      mips_isa_pkg::reg_idx_t wsel;
      mips_isa_pkg::word_t    wdat;
      logic                   regwr;
      logic                   illegal;
   } ex_wb_t;

   // one record per retired instruction
   typedef struct packed {
      mips_isa_pkg::reg_idx_t wsel;
      mips_isa_pkg::word_t    wdat;
      logic                   regwr;
      logic                   illegal;   // unsupported opcode or funct
   } retire_t;

endpackage

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
// MIPS instruction set definitions
// register and word types, the supported major opcodes and R-type
// function codes, and the operation encoding of the ALU
`default_nettype none

package mips_isa_pkg;

   typedef logic [4:0]  reg_idx_t;   // register number
   typedef logic [31:0] word_t;      // data word

   //////////////////////////////////////////////////////////////////////
   // instruction encodings
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,   // funct picks the operation
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0a,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f
   } opcode_t;

   typedef enum logic [5:0] {
      F_SLL  = 6'h00,
      F_SRL  = 6'h02,
      F_ADDU = 6'h21,
      F_SUBU = 6'h23,
      F_AND  = 6'h24,
      F_OR   = 6'h25,
      F_XOR  = 6'h26,
      F_NOR  = 6'h27,
      F_SLT  = 6'h2a,
      F_SLTU = 6'h2b
   } funct_t;

   // alu operations
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
   } alu_op_t;

endpackage

`default_nettype wire
